/* hw/rv64_settings.svh */
`ifndef RV64_SETTINGS_SVH
`define RV64_SETTINGS_SVH

// Core widths
`define RV_XLEN 64
`define RV_ILEN 32
`define RV_NREGS 32

// First fetch address
`define RV_RESET_PC 64'h0

// One select bit per data byte
`define RV_WB_SEL_W 8

`endif

/* hw/rv64_pkg.sv */
`default_nettype none

`include "rv64_settings.svh"

package rv64_pkg;

    typedef logic [`RV_XLEN-1:0] xlen_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;
    typedef logic [`RV_WB_SEL_W-1:0] wb_sel_t;

    // Major opcodes handled by the core, anything else retires as a no-op
    typedef enum logic [6:0] {
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_OP_32     = 7'b0111011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // Same encoding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE   = 2'd0,
        MEM_HALF   = 2'd1,
        MEM_WORD   = 2'd2,
        MEM_DOUBLE = 2'd3
    } mem_size_e;

endpackage

`default_nettype wire

/* hw/rv64_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv64_settings.svh"

module rv64_decoder (
    input wire [`RV_ILEN-1:0] instr,
    output rv64_pkg::reg_idx_t rs1,
    output rv64_pkg::reg_idx_t rs2,
    output rv64_pkg::reg_idx_t rd,
    output rv64_pkg::xlen_t imm,
    output rv64_pkg::alu_op_e alu_op,
    output logic use_imm,
    output logic word_op,
    output logic reg_write,
    output logic is_load,
    output logic is_store,
    output logic is_branch,
    output logic is_jal,
    output logic is_jalr,
    output logic is_upper,
    output logic add_pc,
    output logic load_unsigned,
    output logic [2:0] branch_funct,
    output rv64_pkg::mem_size_e mem_size
);
    import rv64_pkg::*;

    opcode_e opcode;
    logic [2:0] funct3;
    logic reg_form;
    alu_op_e alu_sel;
    xlen_t imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rd = instr[11:7];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign branch_funct = funct3;
    assign load_unsigned = funct3[2];  // LBU, LHU, LWU
    assign mem_size = mem_size_e'(funct3[1:0]);
    assign reg_form = (opcode == OPC_OP) || (opcode == OPC_OP_32);

    assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {{(`RV_XLEN-32){instr[31]}}, instr[31:12], 12'h000};
    assign imm_j = {{(`RV_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    // Bit 30 picks SUB only in register form, but SRA in both forms
    always_comb begin
        case (funct3)
            3'b000: alu_sel = (reg_form && instr[30]) ? ALU_SUB : ALU_ADD;
            3'b001: alu_sel = ALU_SLL;
            3'b010: alu_sel = ALU_SLT;
            3'b011: alu_sel = ALU_SLTU;
            3'b100: alu_sel = ALU_XOR;
            3'b101: alu_sel = instr[30] ? ALU_SRA : ALU_SRL;
            3'b110: alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    end

    always_comb begin
        imm = '0;
        alu_op = ALU_ADD;
        use_imm = 1'b0;
        word_op = 1'b0;
        reg_write = 1'b0;
        is_load = 1'b0;
        is_store = 1'b0;
        is_branch = 1'b0;
        is_jal = 1'b0;
        is_jalr = 1'b0;
        is_upper = 1'b0;
        add_pc = 1'b0;
        case (opcode)
            OPC_LUI: begin
                reg_write = 1'b1;
                is_upper = 1'b1;
                imm = imm_u;
            end
            OPC_AUIPC: begin
                reg_write = 1'b1;
                is_upper = 1'b1;
                add_pc = 1'b1;  // Upper immediate plus PC
                imm = imm_u;
            end
            OPC_JAL: begin
                reg_write = 1'b1;
                is_jal = 1'b1;
                imm = imm_j;
            end
            OPC_JALR: begin
                reg_write = 1'b1;
                is_jalr = 1'b1;
                imm = imm_i;
            end
            OPC_BRANCH: begin
                is_branch = 1'b1;
                imm = imm_b;
            end
            OPC_LOAD: begin
                reg_write = 1'b1;
                is_load = 1'b1;
                imm = imm_i;
            end
            OPC_STORE: begin
                is_store = 1'b1;
                imm = imm_s;
            end
            OPC_OP_IMM, OPC_OP_IMM_32: begin
                reg_write = 1'b1;
                use_imm = 1'b1;
                word_op = (opcode == OPC_OP_IMM_32);
                alu_op = alu_sel;
                imm = imm_i;  // Shift amount sits in the low bits
            end
            OPC_OP, OPC_OP_32: begin
                reg_write = 1'b1;
                word_op = (opcode == OPC_OP_32);
                alu_op = alu_sel;
            end
            default: reg_write = 1'b0;  // Unknown opcode retires with no effect
        endcase
    end

endmodule

`default_nettype wire

/* hw/rv64_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv64_settings.svh"

module rv64_regfile (
    input wire clock,
    input wire reset_n,
    input wire rv64_pkg::reg_idx_t rs1,
    input wire rv64_pkg::reg_idx_t rs2,
    input wire rv64_pkg::reg_idx_t rd,
    input wire we,
    input wire rv64_pkg::xlen_t wdata,
    output rv64_pkg::xlen_t rdata1,
    output rv64_pkg::xlen_t rdata2
);
    import rv64_pkg::*;

    xlen_t regs [`RV_NREGS];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin  // x0 is never written
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    x0_zero_a: assert property (@(posedge clock) disable iff (!reset_n)
        (regs[0] == '0));

endmodule

`default_nettype wire

/* hw/rv64_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv64_settings.svh"

module rv64_alu (
    input wire rv64_pkg::xlen_t a,
    input wire rv64_pkg::xlen_t b,
    input wire rv64_pkg::alu_op_e alu_op,
    input wire word_op,
    output rv64_pkg::xlen_t result
);
    import rv64_pkg::*;

    logic [5:0] shamt;
    xlen_t a_sext;
    xlen_t a_zext;
    xlen_t raw;

    // Word forms shift by at most 31
    assign shamt = word_op ? {1'b0, b[4:0]} : b[5:0];

    // Right shifts in word mode must see only the low 32 bits
    assign a_sext = {{(`RV_XLEN-32){a[31]}}, a[31:0]};
    assign a_zext = {{(`RV_XLEN-32){1'b0}}, a[31:0]};

    always_comb begin
        case (alu_op)
            ALU_ADD: raw = a + b;
            ALU_SUB: raw = a - b;
            ALU_SLT: raw = xlen_t'($signed(a) < $signed(b));
            ALU_SLTU: raw = xlen_t'(a < b);
            ALU_XOR: raw = a ^ b;
            ALU_OR: raw = a | b;
            ALU_AND: raw = a & b;
            ALU_SLL: raw = a << shamt;
            ALU_SRL: raw = (word_op ? a_zext : a) >> shamt;
            ALU_SRA: raw = $signed(word_op ? a_sext : a) >>> shamt;
            default: raw = '0;
        endcase
    end

    // Word results are always sign-extended from bit 31
    assign result = word_op ? {{(`RV_XLEN-32){raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

/* hw/rv64_flow_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv64_settings.svh"

module rv64_flow_unit (
    input wire rv64_pkg::xlen_t pc,
    input wire rv64_pkg::xlen_t rs1_val,
    input wire rv64_pkg::xlen_t rs2_val,
    input wire rv64_pkg::xlen_t imm,
    input wire is_branch,
    input wire is_jal,
    input wire is_jalr,
    input wire [2:0] branch_funct,
    output logic taken,
    output rv64_pkg::xlen_t target,
    output rv64_pkg::xlen_t link,
    output rv64_pkg::xlen_t mem_addr
);
    import rv64_pkg::*;

    xlen_t rel_target;
    logic eq;
    logic lt;
    logic ltu;
    logic cond;

    assign eq = (rs1_val == rs2_val);
    assign lt = ($signed(rs1_val) < $signed(rs2_val));
    assign ltu = (rs1_val < rs2_val);

    always_comb begin
        case (branch_funct)
            3'b000: cond = eq;    // BEQ
            3'b001: cond = !eq;   // BNE
            3'b100: cond = lt;    // BLT
            3'b101: cond = !lt;   // BGE
            3'b110: cond = ltu;   // BLTU
            3'b111: cond = !ltu;  // BGEU
            default: cond = 1'b0;
        endcase
    end

    // JALR shares the rs1 + imm adder with loads and stores
    assign mem_addr = rs1_val + imm;
    assign rel_target = pc + imm;
    assign target = is_jalr ? {mem_addr[`RV_XLEN-1:1], 1'b0} : rel_target;
    assign link = pc + `RV_XLEN'(4);
    assign taken = is_jal || is_jalr || (is_branch && cond);

endmodule

`default_nettype wire

/* hw/rv64_retire_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv64_settings.svh"

module rv64_retire_unit (
    input wire clock,
    input wire reset_n,
    input wire instr_valid,
    input wire reg_write,
    input wire is_load,
    input wire is_store,
    input wire is_jal,
    input wire is_jalr,
    input wire is_upper,
    input wire add_pc,
    input wire load_unsigned,
    input wire rv64_pkg::reg_idx_t rd,
    input wire rv64_pkg::mem_size_e mem_size,
    input wire rv64_pkg::xlen_t alu_result,
    input wire taken,
    input wire rv64_pkg::xlen_t target,
    input wire rv64_pkg::xlen_t link,
    input wire rv64_pkg::xlen_t mem_addr,
    input wire rv64_pkg::xlen_t imm,
    input wire rv64_pkg::xlen_t store_val,
    output rv64_pkg::xlen_t pc,
    output logic instr_ready,
    output logic rf_we,
    output rv64_pkg::reg_idx_t rf_rd,
    output rv64_pkg::xlen_t rf_wdata,
    output logic wb_cyc,
    output logic wb_stb,
    output logic wb_we,
    output rv64_pkg::xlen_t wb_adr,
    output rv64_pkg::xlen_t wb_dat_o,
    output rv64_pkg::wb_sel_t wb_sel,
    input wire rv64_pkg::xlen_t wb_dat_i,
    input wire wb_ack
);
    import rv64_pkg::*;

    typedef enum logic {ST_IDLE, ST_MEM} state_e;

    state_e state;
    logic accept;
    logic mem_op;
    logic ld_sign;
    logic [2:0] align_mask;
    wb_sel_t sel_next;
    xlen_t wb_value;
    xlen_t lane_data;
    xlen_t load_val;
    reg_idx_t ld_rd;
    mem_size_e ld_size;
    logic ld_unsigned;
    logic [2:0] ld_lane;

    assign instr_ready = (state == ST_IDLE);
    assign accept = instr_valid && instr_ready;
    assign mem_op = is_load || is_store;

    always_comb begin
        if (is_jal || is_jalr) begin
            wb_value = link;
        end else if (is_upper) begin
            wb_value = add_pc ? pc + imm : imm;  // AUIPC or LUI
        end else begin
            wb_value = alu_result;
        end
    end

    always_comb begin
        case (mem_size)
            MEM_BYTE: sel_next = 8'h01 << mem_addr[2:0];
            MEM_HALF: sel_next = 8'h03 << mem_addr[2:0];
            MEM_WORD: sel_next = 8'h0f << mem_addr[2:0];
            default: sel_next = 8'hff;
        endcase
    end

    // Move the addressed lane down to bit 0, then extend
    assign lane_data = wb_dat_i >> {ld_lane, 3'b000};
    always_comb begin
        case (ld_size)
            MEM_BYTE: ld_sign = !ld_unsigned && lane_data[7];
            MEM_HALF: ld_sign = !ld_unsigned && lane_data[15];
            default: ld_sign = !ld_unsigned && lane_data[31];
        endcase
        case (ld_size)
            MEM_BYTE: load_val = {{(`RV_XLEN-8){ld_sign}}, lane_data[7:0]};
            MEM_HALF: load_val = {{(`RV_XLEN-16){ld_sign}}, lane_data[15:0]};
            MEM_WORD: load_val = {{(`RV_XLEN-32){ld_sign}}, lane_data[31:0]};
            default: load_val = lane_data;
        endcase
    end

    // Loads write back on the ack edge, everything else on the accepting edge
    assign rf_we = (state == ST_MEM) ? (wb_ack && !wb_we) : (accept && reg_write && !mem_op);
    assign rf_rd = (state == ST_MEM) ? ld_rd : rd;
    assign rf_wdata = (state == ST_MEM) ? load_val : wb_value;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= ST_IDLE;
            pc <= `RV_RESET_PC;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we <= 1'b0;
        end else if (state == ST_IDLE) begin
            if (accept && mem_op) begin
                state <= ST_MEM;
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
                wb_we <= is_store;
            end else if (accept) begin
                pc <= taken ? target : link;  // Link is PC + 4
            end
        end else if (wb_ack) begin
            state <= ST_IDLE;
            pc <= link;  // PC is unchanged while waiting
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we <= 1'b0;
        end
    end

    // Bus address is doubleword aligned, the lane goes in wb_sel
    always_ff @(posedge clock) begin
        if (accept && mem_op) begin
            wb_adr <= {mem_addr[`RV_XLEN-1:3], 3'b000};
            wb_dat_o <= store_val << {mem_addr[2:0], 3'b000};
            wb_sel <= sel_next;
            ld_rd <= rd;
            ld_size <= mem_size;
            ld_unsigned <= load_unsigned;
            ld_lane <= mem_addr[2:0];
        end
    end

    assign align_mask = 3'((4'd1 << mem_size) - 4'd1);

    mem_aligned_a: assert property (@(posedge clock) disable iff (!reset_n)
        (accept && mem_op) |-> ((mem_addr[2:0] & align_mask) == 3'b000));

    wb_hold_a: assert property (@(posedge clock) disable iff (!reset_n)
        (wb_stb && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_we) && $stable(wb_adr)
            && $stable(wb_dat_o) && $stable(wb_sel)));

endmodule

`default_nettype wire

/* hw/rv64_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv64_settings.svh"

module rv64_core (
    input wire clock,
    input wire reset_n,
    input wire [`RV_ILEN-1:0] instr,
    input wire instr_valid,
    output wire instr_ready,
    output wire rv64_pkg::xlen_t pc,
    output wire wb_cyc,
    output wire wb_stb,
    output wire wb_we,
    output wire rv64_pkg::xlen_t wb_adr,
    output wire rv64_pkg::xlen_t wb_dat_o,
    output wire rv64_pkg::wb_sel_t wb_sel,
    input wire rv64_pkg::xlen_t wb_dat_i,
    input wire wb_ack
);
    import rv64_pkg::*;

    wire reg_idx_t rs1, rs2, rd, rf_rd;
    wire xlen_t imm, rs1_val, rs2_val, alu_result, rf_wdata;
    wire xlen_t target, link, mem_addr;
    wire alu_op_e alu_op;
    wire mem_size_e mem_size;
    wire [2:0] branch_funct;
    wire use_imm, word_op, reg_write, is_load, is_store, is_branch;
    wire is_jal, is_jalr, is_upper, add_pc, load_unsigned, taken, rf_we;

    // Second ALU operand
    wire xlen_t alu_b = use_imm ? imm : rs2_val;

    rv64_decoder rv64_decoder_inst (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
        .use_imm(use_imm), .word_op(word_op), .reg_write(reg_write), .is_load(is_load),
        .is_store(is_store), .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
        .is_upper(is_upper), .add_pc(add_pc), .load_unsigned(load_unsigned),
        .branch_funct(branch_funct), .mem_size(mem_size)
    );

    rv64_regfile rv64_regfile_inst (
        .clock(clock), .reset_n(reset_n), .rs1(rs1), .rs2(rs2), .rd(rf_rd),
        .we(rf_we), .wdata(rf_wdata), .rdata1(rs1_val), .rdata2(rs2_val)
    );

    rv64_alu rv64_alu_inst (
        .a(rs1_val), .b(alu_b), .alu_op(alu_op), .word_op(word_op), .result(alu_result)
    );

    rv64_flow_unit rv64_flow_unit_inst (
        .pc(pc), .rs1_val(rs1_val), .rs2_val(rs2_val), .imm(imm), .is_branch(is_branch),
        .is_jal(is_jal), .is_jalr(is_jalr), .branch_funct(branch_funct), .taken(taken),
        .target(target), .link(link), .mem_addr(mem_addr)
    );

    rv64_retire_unit rv64_retire_unit_inst (
        .clock(clock), .reset_n(reset_n), .instr_valid(instr_valid),
        .reg_write(reg_write), .is_load(is_load), .is_store(is_store), .is_jal(is_jal),
        .is_jalr(is_jalr), .is_upper(is_upper), .add_pc(add_pc),
        .load_unsigned(load_unsigned), .rd(rd), .mem_size(mem_size),
        .alu_result(alu_result), .taken(taken), .target(target), .link(link),
        .mem_addr(mem_addr), .imm(imm), .store_val(rs2_val), .pc(pc),
        .instr_ready(instr_ready), .rf_we(rf_we), .rf_rd(rf_rd), .rf_wdata(rf_wdata),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o), .wb_sel(wb_sel), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

endmodule

`default_nettype wire

/* tests/tb_rv64_ref.svh */
`ifndef TB_RV64_REF_SVH
`define TB_RV64_REF_SVH

// Instruction-level model of the core
logic [63:0] ref_regs [32];
logic [63:0] ref_pc;
logic [7:0] ref_mem [logic [63:0]];

// Bus access expected from the last store
logic exp_store;
logic [63:0] exp_adr;
logic [63:0] exp_data;
logic [7:0] exp_sel;

// Background memory content, different for every address
function automatic logic [7:0] fill_byte(input logic [63:0] a);
    logic [63:0] h;
    h = a ^ (a >> 23) ^ (a >> 41);
    h = h * 64'h9e3779b97f4a7c15;
    return h[63:56] ^ h[7:0];
endfunction

function automatic logic [7:0] ref_byte(input logic [63:0] a);
    if (ref_mem.exists(a)) begin
        return ref_mem[a];
    end
    return fill_byte(a);
endfunction

function automatic logic [63:0] ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic reg_form, input logic word,
                                        input logic [63:0] a, input logic [63:0] b);
    logic [63:0] r;
    logic [5:0] sh;
    logic [31:0] aw;
    sh = word ? {1'b0, b[4:0]} : b[5:0];
    aw = a[31:0];
    r = '0;
    case (f3)
        3'd0: r = (alt && reg_form) ? a - b : a + b;
        3'd1: r = a << sh;
        3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        3'd3: r = (a < b) ? 64'd1 : 64'd0;
        3'd4: r = a ^ b;
        3'd5: begin
            if (word && alt) r = 64'($signed(aw) >>> sh);
            else if (word) r = 64'(aw >> sh);
            else if (alt) r = $signed(a) >>> sh;
            else r = a >> sh;
        end
        3'd6: r = a | b;
        default: r = a & b;
    endcase
    if (word) r = {{32{r[31]}}, r[31:0]};  // Word results sign-extend
    return r;
endfunction

// Executes one instruction on the model state
function automatic void ref_exec(input logic [31:0] ins);
    logic [63:0] a, b, res, addr, nxt;
    logic [63:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [2:0] f3;
    logic wr, tk;
    int n;
    a = ref_regs[ins[19:15]];
    b = ref_regs[ins[24:20]];
    f3 = ins[14:12];
    imm_i = {{52{ins[31]}}, ins[31:20]};
    imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {{32{ins[31]}}, ins[31:12], 12'h000};
    imm_j = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    nxt = ref_pc + 64'd4;
    res = '0;
    wr = 1'b0;
    exp_store = 1'b0;
    n = 1 << ins[13:12];  // Access size in bytes
    case (ins[6:0])
        7'h37: begin res = imm_u; wr = 1'b1; end
        7'h17: begin res = ref_pc + imm_u; wr = 1'b1; end
        7'h6f: begin res = ref_pc + 64'd4; nxt = ref_pc + imm_j; wr = 1'b1; end
        7'h67: begin res = ref_pc + 64'd4; nxt = (a + imm_i) & ~64'd1; wr = 1'b1; end
        7'h63: begin
            case (f3)
                3'd0: tk = (a == b);
                3'd1: tk = (a != b);
                3'd4: tk = ($signed(a) < $signed(b));
                3'd5: tk = !($signed(a) < $signed(b));
                3'd6: tk = (a < b);
                3'd7: tk = (a >= b);
                default: tk = 1'b0;
            endcase
            if (tk) nxt = ref_pc + imm_b;
        end
        7'h03: begin
            addr = a + imm_i;
            for (int i = 0; i < n; i++) res |= 64'(ref_byte(addr + 64'(i))) << (8 * i);
            if (!ins[14]) begin
                res = res << (64 - 8 * n);
                res = $signed(res) >>> (64 - 8 * n);
            end
            wr = 1'b1;
        end
        7'h23: begin
            addr = a + imm_s;
            exp_store = 1'b1;
            exp_adr = addr & ~64'd7;
            exp_sel = 8'((1 << n) - 1) << addr[2:0];
            exp_data = b << (8 * addr[2:0]);
            for (int i = 0; i < n; i++) ref_mem[addr + 64'(i)] = 8'(b >> (8 * i));
        end
        7'h13: begin res = ref_alu(f3, ins[30], 1'b0, 1'b0, a, imm_i); wr = 1'b1; end
        7'h1b: begin res = ref_alu(f3, ins[30], 1'b0, 1'b1, a, imm_i); wr = 1'b1; end
        7'h33: begin res = ref_alu(f3, ins[30], 1'b1, 1'b0, a, b); wr = 1'b1; end
        7'h3b: begin res = ref_alu(f3, ins[30], 1'b1, 1'b1, a, b); wr = 1'b1; end
        default: wr = 1'b0;  // Unknown opcodes change nothing but the PC
    endcase
    if (wr && ins[11:7] != 5'd0) ref_regs[ins[11:7]] = res;
    ref_pc = nxt;
endfunction

`endif

/* tests/tb_rv64_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv64_settings.svh"

module tb_rv64_core;
    localparam int NTESTS = 6;
    localparam logic [31:0] NOP = 32'h00000013;

    logic clock;
    logic reset_n;
    logic [31:0] instr;
    logic instr_valid;
    wire instr_ready;
    wire [63:0] pc;
    wire wb_cyc, wb_stb, wb_we;
    wire [63:0] wb_adr, wb_dat_o;
    wire [7:0] wb_sel;
    logic [63:0] wb_dat_i;
    logic wb_ack;

    logic [31:0] prog [1024];
    logic [7:0] bus_mem [logic [63:0]];
    logic [63:0] emit_pc;
    logic [63:0] test_end [NTESTS];
    string test_names [NTESTS];
    logic [63:0] lane_word;
    logic retire, mem_busy;
    int res_off, wait_left, cycles, cycle_limit;
    int errors, test_errors, cur_test, tests_clean;

    `include "tb_rv64_ref.svh"

    rv64_core rv64_core_inst (
        .clock(clock), .reset_n(reset_n), .instr(instr), .instr_valid(instr_valid),
        .instr_ready(instr_ready), .pc(pc), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_sel(wb_sel),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    always #50 clock = ~clock;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[emit_pc[11:2]] = w;
        emit_pc = emit_pc + 64'd4;
    endtask

    // Random 64-bit operand from LUI, ADDI and a shift
    task automatic put_const(input logic [4:0] rd);
        emit({20'($urandom), rd, 7'h37});
        emit(enc_i(12'($urandom), rd, 3'd0, rd, 7'h13));
        emit(enc_i({6'd0, 6'($urandom % 40)}, rd, 3'd1, rd, 7'h13));
        emit(enc_i(12'($urandom), rd, 3'd0, rd, 7'h13));
    endtask

    task automatic put_word_const(input logic [4:0] rd);
        emit({1'b1, 19'($urandom), rd, 7'h37});  // Bit 31 set
        emit(enc_i(12'($urandom), rd, 3'd0, rd, 7'h13));
    endtask

    // Results go to the data area at x31
    task automatic save(input logic [4:0] rs);
        emit(enc_s(12'(res_off), rs, 5'd31, 3'd3));
        res_off += 8;
    endtask

    task automatic alu_case(input logic [2:0] f3, input logic alt, input logic word);
        logic [11:0] imm;
        if (word) begin
            put_word_const(5'd1);
            put_word_const(5'd2);
        end else begin
            put_const(5'd1);
            put_const(5'd2);
        end
        emit(enc_r({1'b0, alt, 5'd0}, 5'd2, 5'd1, f3, 5'd3, word ? 7'h3b : 7'h33));
        save(5'd3);
        if (!(f3 == 3'd0 && alt)) begin
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = {1'b0, alt, 4'd0, 6'($urandom % (word ? 32 : 64))};
            end else begin
                imm = 12'($urandom);
            end
            emit(enc_i(imm, 5'd1, f3, 5'd4, word ? 7'h1b : 7'h13));
            save(5'd4);
        end
    endtask

    task automatic mem_case(input logic [1:0] size);
        logic [11:0] off;
        logic [2:0] lane;
        lane = 3'($urandom) & ~3'((1 << size) - 1);
        off = 12'h400 + 12'(($urandom % 96) * 8) + 12'(lane);
        put_const(5'd5);
        emit(enc_s(off, 5'd5, 5'd31, {1'b0, size}));
        emit(enc_i(off, 5'd31, {1'b0, size}, 5'd6, 7'h03));
        save(5'd6);
        if (size != 2'd3) begin
            emit(enc_i(off, 5'd31, {1'b1, size}, 5'd7, 7'h03));  // Unsigned form
            save(5'd7);
        end
    endtask

    task automatic branch_case(input logic [2:0] f3, input int kind);
        put_const(5'd1);
        if (kind == 0) emit(enc_i(12'd0, 5'd1, 3'd0, 5'd2, 7'h13));
        else if (kind == 1) put_const(5'd2);
        else emit(enc_r(7'h20, 5'd1, 5'd0, 3'd0, 5'd2, 7'h33));
        emit(enc_b(13'd8, 5'd2, 5'd1, f3));
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd7, 7'h13));  // Skipped when taken
        emit(enc_b(13'd8, 5'd1, 5'd2, f3));  // Operands swapped
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd7, 7'h13));
    endtask

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            $display("** Error %s %s: expected %h, actual %h",
                     test_names[cur_test], what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    initial begin
        void'($urandom(32'hf1a746b0));
        clock = 1'b0;
        reset_n = 1'b0;
        instr = NOP;
        instr_valid = 1'b0;
        wb_dat_i = '0;
        wb_ack = 1'b0;
        mem_busy = 1'b0;
        for (int i = 0; i < 1024; i++) prog[i] = NOP;
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        ref_pc = `RV_RESET_PC;
        emit_pc = `RV_RESET_PC;
        res_off = 0;
        test_names = '{"alu", "word_ops", "load_store", "branches", "jumps", "x0"};

        emit({20'h1, 5'd31, 7'h37});  // Data area at 0x1000
        for (int k = 0; k < 8; k++) alu_case(3'(k), 1'b0, 1'b0);
        alu_case(3'd0, 1'b1, 1'b0);
        alu_case(3'd5, 1'b1, 1'b0);
        test_end[0] = emit_pc;
        alu_case(3'd0, 1'b0, 1'b1);
        alu_case(3'd0, 1'b1, 1'b1);
        alu_case(3'd1, 1'b0, 1'b1);
        alu_case(3'd5, 1'b0, 1'b1);
        alu_case(3'd5, 1'b1, 1'b1);
        test_end[1] = emit_pc;
        for (int k = 0; k < 8; k++) mem_case(2'(k));
        test_end[2] = emit_pc;
        for (int k = 0; k < 8; k++) begin
            if (k != 2 && k != 3) begin
                for (int m = 0; m < 3; m++) branch_case(3'(k), m);
            end
        end
        test_end[3] = emit_pc;
        emit(enc_j(21'd8, 5'd1));
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd7, 7'h13));
        save(5'd1);
        emit({20'($urandom), 5'd4, 7'h17});
        save(5'd4);
        emit({20'd0, 5'd5, 7'h17});
        emit(enc_i(12'd13, 5'd5, 3'd0, 5'd6, 7'h67));  // Lands 12 bytes past AUIPC
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd7, 7'h13));
        save(5'd6);
        test_end[4] = emit_pc;
        emit(enc_i(12'($urandom), 5'd0, 3'd0, 5'd0, 7'h13));
        emit({20'($urandom), 5'd0, 7'h37});
        save(5'd0);
        test_end[5] = emit_pc;
        emit(enc_j(21'd0, 5'd0));  // Park

        // Worst case per instruction is a bubble, valid drops and a slow ack
        cycle_limit = int'(emit_pc >> 2) * 16 + 1000;
        repeat (10) @(posedge clock);
        reset_n <= 1'b1;
    end

    // Instruction source that drops valid while pc moves
    always @(posedge clock) begin
        if (!reset_n) begin
            instr_valid <= 1'b0;
        end else if ((instr_valid && instr_ready) || (wb_cyc && wb_ack)) begin
            instr_valid <= 1'b0;
        end else begin
            instr <= (pc < 64'd4096) ? prog[pc[11:2]] : NOP;
            instr_valid <= ($urandom % 4) != 0;
        end
    end

    // Wishbone memory with 0 to 3 wait cycles
    always @(posedge clock) begin
        if (!reset_n) begin
            wb_ack <= 1'b0;
            wait_left = $urandom % 4;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (wait_left == 0) begin
                for (int i = 0; i < 8; i++) begin
                    if (wb_we && wb_sel[i]) bus_mem[wb_adr + 64'(i)] = wb_dat_o[8*i +: 8];
                    lane_word[8*i +: 8] = bus_mem.exists(wb_adr + 64'(i)) ?
                        bus_mem[wb_adr + 64'(i)] : fill_byte(wb_adr + 64'(i));
                end
                wb_dat_i <= lane_word;
                wb_ack <= 1'b1;
                wait_left = $urandom % 4;
            end else begin
                wait_left--;
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the core stopped retiring after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // Compare process that steps the model at each retirement
    always begin
        @(posedge clock);
        retire = 1'b0;
        if (reset_n) begin
            // Bus cycle open exactly while a load or store is outstanding
            check_value("wb_cyc", 64'(mem_busy), 64'(wb_cyc));
            check_value("wb_stb", 64'(mem_busy), 64'(wb_stb));
            check_value("instr_ready", 64'(!mem_busy), 64'(instr_ready));
            if (wb_cyc && wb_stb && wb_ack) begin
                check_value("wb_we", 64'(exp_store), 64'(wb_we));
                if (exp_store) begin
                    check_value("wb_adr", exp_adr, wb_adr);
                    check_value("wb_sel", 64'(exp_sel), 64'(wb_sel));
                    for (int i = 0; i < 8; i++) begin
                        if (exp_sel[i]) check_value("store lane", 64'(exp_data[8*i +: 8]),
                                                    64'(wb_dat_o[8*i +: 8]));
                    end
                end
                mem_busy = 1'b0;
                retire = 1'b1;
            end else if (instr_valid && instr_ready) begin
                if (instr[6:0] == 7'h03 || instr[6:0] == 7'h23) mem_busy = 1'b1;
                else retire = 1'b1;
                ref_exec(instr);
            end
        end
        if (retire) begin
            @(negedge clock);
            check_value("pc", ref_pc, pc);
            while (cur_test < NTESTS && ref_pc == test_end[cur_test]) begin
                $display("test %0d %s finished with %0d errors",
                         cur_test, test_names[cur_test], test_errors);
                if (test_errors == 0) tests_clean++;
                test_errors = 0;
                cur_test++;
            end
            if (cur_test == NTESTS) begin
                $display("%0d of %0d tests clean, %0d errors", tests_clean, NTESTS, errors);
                if (errors == 0) begin
                    $display("all tests passed");
                end else begin
                    $display("tests failed");
                end
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+hw
+incdir+tests
hw/rv64_pkg.sv
hw/rv64_decoder.sv
hw/rv64_regfile.sv
hw/rv64_alu.sv
hw/rv64_flow_unit.sv
hw/rv64_retire_unit.sv
hw/rv64_core.sv
tests/tb_rv64_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the RV64 core testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

mkdir -p build
if [ $? -ne 0 ]; then
    echo "cannot create build directory"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_rv64_core -Mdir build/obj
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./build/obj/Vtb_rv64_core > build/sim.log 2>&1
status=$?
cat build/sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^all tests passed$" build/sim.log; then
    exit 0
fi
echo "pass message not found in build/sim.log"
exit 1
